/* source/rv_wb_pkg.sv */
/*
 * Writeback shared definitions
 * Word and register index types, result-source encoding and load widths
 */

package rv_wb_pkg;

    // ========================================
    // Basic types
    // ========================================

    // Data word for results, load data, PC and register contents
    typedef logic [31:0] word_t;

    // Register index, always 5 bits even for RV32E
    typedef logic [4:0] reg_addr_t;

    // ========================================
    // Writeback result source
    // ========================================

    // Values 5..7 are undefined and write zero
    typedef enum logic [2:0] {
        WB_SEL_ALU   = 3'd0,
        WB_SEL_MEM   = 3'd1,
        WB_SEL_PC_P4 = 3'd2,
        WB_SEL_CSR   = 3'd3,
        WB_SEL_MDU   = 3'd4
    } wb_sel_e;

    // ========================================
    // Load width codes
    // ========================================

    // Same values as the RISC-V load funct3 field
    typedef logic [2:0] load_funct3_t;

    // Signed byte, halfword and word
    localparam load_funct3_t LD_B  = 3'b000;
    localparam load_funct3_t LD_H  = 3'b001;
    localparam load_funct3_t LD_W  = 3'b010;
    // Unsigned byte and halfword
    localparam load_funct3_t LD_BU = 3'b100;
    localparam load_funct3_t LD_HU = 3'b101;

endpackage

/* source/mem_wb_reg.sv */
/*
 * MEM/WB pipeline register
 * Captures one retiring instruction per mem_valid_i strobe
 */

`timescale 1ns/1ps

module mem_wb_reg (
    input  logic                   clk_i,
    input  logic                   rst_i,
    // Retirement strobe from the memory stage
    input  logic                   mem_valid_i,
    input  logic                   reg_write_i,
    input  rv_wb_pkg::reg_addr_t    rd_addr_i,
    input  rv_wb_pkg::wb_sel_e      wb_sel_i,
    // Candidate results
    input  rv_wb_pkg::word_t        alu_result_i,
    input  rv_wb_pkg::word_t        load_data_i,
    input  rv_wb_pkg::word_t        pc_i,
    input  rv_wb_pkg::word_t        csr_data_i,
    input  rv_wb_pkg::word_t        mdu_result_i,
    // Load formatting controls
    input  rv_wb_pkg::load_funct3_t load_funct3_i,
    input  logic [1:0]             addr_offset_i,
    // Registered copy toward writeback
    output logic                   valid_o,
    output logic                   reg_write_o,
    output rv_wb_pkg::reg_addr_t    rd_addr_o,
    output rv_wb_pkg::wb_sel_e      wb_sel_o,
    output rv_wb_pkg::word_t        alu_result_o,
    output rv_wb_pkg::word_t        load_data_o,
    output rv_wb_pkg::word_t        pc_o,
    output rv_wb_pkg::word_t        csr_data_o,
    output rv_wb_pkg::word_t        mdu_result_o,
    output rv_wb_pkg::load_funct3_t load_funct3_o,
    output logic [1:0]             addr_offset_o
);

    // ========================================
    // Valid bit
    // ========================================

    // Drops on any cycle without a strobe
    // so an idle cycle commits nothing
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= mem_valid_i;
        end
    end

    // ========================================
    // Payload fields
    // ========================================

    // Loaded only on a strobe, held otherwise
    // Stale contents are harmless while valid_o is low
    always_ff @(posedge clk_i) begin
        if (mem_valid_i) begin
            reg_write_o   <= reg_write_i;
            rd_addr_o     <= rd_addr_i;
            wb_sel_o      <= wb_sel_i;
            alu_result_o  <= alu_result_i;
            load_data_o   <= load_data_i;
            pc_o          <= pc_i;
            csr_data_o    <= csr_data_i;
            mdu_result_o  <= mdu_result_i;
            load_funct3_o <= load_funct3_i;
            addr_offset_o <= addr_offset_i;
        end
    end

endmodule

/* source/writeback_stage.sv */
/*
 * Writeback stage
 * Formats load data and selects the value written to the register file
 */

`timescale 1ns/1ps

module writeback_stage (
    input  logic                   valid_i,
    input  logic                   reg_write_i,
    input  rv_wb_pkg::reg_addr_t    rd_addr_i,
    input  rv_wb_pkg::wb_sel_e      wb_sel_i,
    input  rv_wb_pkg::word_t        alu_result_i,
    input  rv_wb_pkg::word_t        load_data_i,
    input  rv_wb_pkg::load_funct3_t load_funct3_i,
    input  logic [1:0]             addr_offset_i,
    input  rv_wb_pkg::word_t        pc_i,
    input  rv_wb_pkg::word_t        csr_data_i,
    input  rv_wb_pkg::word_t        mdu_result_i,
    // Register file write port and bypass source
    output logic                   we_o,
    output rv_wb_pkg::reg_addr_t    rd_o,
    output rv_wb_pkg::word_t        data_o
);

    import rv_wb_pkg::*;

    // Load word aligned so the addressed byte sits in bits 7:0
    word_t load_shifted;
    // Sign- or zero-extended load value
    word_t load_fmt;

    // ========================================
    // Load formatting
    // ========================================

    // Offset in bytes, shift in bits
    assign load_shifted = load_data_i >> {addr_offset_i, 3'b000};

    always_comb begin
        case (load_funct3_i)
            LD_B:    load_fmt = {{24{load_shifted[7]}}, load_shifted[7:0]};
            LD_H:    load_fmt = {{16{load_shifted[15]}}, load_shifted[15:0]};
            LD_BU:   load_fmt = {24'd0, load_shifted[7:0]};
            LD_HU:   load_fmt = {16'd0, load_shifted[15:0]};
            // LD_W, plus any unused code, takes the raw word
            default: load_fmt = load_data_i;
        endcase
    end

    // ========================================
    // Result selection
    // ========================================

    always_comb begin
        case (wb_sel_i)
            WB_SEL_ALU:   data_o = alu_result_i;
            WB_SEL_MEM:   data_o = load_fmt;
            // Link value for JAL and JALR
            WB_SEL_PC_P4: data_o = pc_i + 32'd4;
            WB_SEL_CSR:   data_o = csr_data_i;
            WB_SEL_MDU:   data_o = mdu_result_i;
            // Undefined selector writes zero
            default:      data_o = '0;
        endcase
    end

    // ========================================
    // Write port control
    // ========================================

    // Only a live instruction that writes rd commits
    assign we_o = valid_i & reg_write_i;
    assign rd_o = rd_addr_i;

endmodule

/* source/reg_file.sv */
/*
 * Integer register file
 * One write port, two combinational read ports, x0 hard-wired to zero
 */

`timescale 1ns/1ps

module reg_file #(
    // 32 for RV32I, 16 for RV32E
    parameter int NUM_REGS = 32
) (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                we_i,
    input  rv_wb_pkg::reg_addr_t waddr_i,
    input  rv_wb_pkg::word_t     wdata_i,
    input  rv_wb_pkg::reg_addr_t raddr1_i,
    input  rv_wb_pkg::reg_addr_t raddr2_i,
    output rv_wb_pkg::word_t     rdata1_o,
    output rv_wb_pkg::word_t     rdata2_o
);

    import rv_wb_pkg::*;

    word_t regs [NUM_REGS];

    // Write lands at the edge that ends the commit cycle
    // x0 and unimplemented indices are dropped
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0) && (int'(waddr_i) < NUM_REGS)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // ========================================
    // Read ports
    // ========================================

    // x0 and indices past NUM_REGS read as zero
    assign rdata1_o = ((raddr1_i != '0) && (int'(raddr1_i) < NUM_REGS)) ?
                      regs[raddr1_i] : '0;
    assign rdata2_o = ((raddr2_i != '0) && (int'(raddr2_i) < NUM_REGS)) ?
                      regs[raddr2_i] : '0;

endmodule

/* source/operand_bypass.sv */
/*
 * Operand bypass
 * Forwards the committing writeback value onto matching read ports
 */

`timescale 1ns/1ps

module operand_bypass #(
    // Must match the register file so forwarding agrees with storage
    parameter int NUM_REGS = 32
) (
    input  rv_wb_pkg::reg_addr_t raddr1_i,
    input  rv_wb_pkg::reg_addr_t raddr2_i,
    // Stored values from the register file
    input  rv_wb_pkg::word_t     rf_data1_i,
    input  rv_wb_pkg::word_t     rf_data2_i,
    // Commit in flight this cycle
    input  logic                wb_we_i,
    input  rv_wb_pkg::reg_addr_t wb_rd_i,
    input  rv_wb_pkg::word_t     wb_data_i,
    output rv_wb_pkg::word_t     op1_o,
    output rv_wb_pkg::word_t     op2_o
);

    // Commit will really be stored
    logic wb_fwd_ok;
    // Per-port address hits
    logic hit1;
    logic hit2;

    // No forwarding for x0 or an index the register file drops
    assign wb_fwd_ok = wb_we_i && (wb_rd_i != '0) && (int'(wb_rd_i) < NUM_REGS);

    assign hit1 = wb_fwd_ok && (raddr1_i == wb_rd_i);
    assign hit2 = wb_fwd_ok && (raddr2_i == wb_rd_i);

    // ========================================
    // Operand select
    // ========================================

    // Covers the cycle before the write edge
    assign op1_o = hit1 ? wb_data_i : rf_data1_i;
    assign op2_o = hit2 ? wb_data_i : rf_data2_i;

endmodule

/* source/wb_subsystem.sv */
/*
 * Pipeline back end
 * MEM/WB register, writeback stage, register file and operand bypass
 * Commit is visible through the bypass in the cycle after the strobe
 */

`timescale 1ns/1ps

module wb_subsystem #(
    // 32 for RV32I, 16 for RV32E
    parameter int NUM_REGS = 32
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    // Retiring instruction from the memory stage
    input  logic                   mem_valid_i,
    input  logic                   reg_write_i,
    input  rv_wb_pkg::reg_addr_t    rd_addr_i,
    input  rv_wb_pkg::wb_sel_e      wb_sel_i,
    input  rv_wb_pkg::word_t        alu_result_i,
    input  rv_wb_pkg::word_t        load_data_i,
    input  rv_wb_pkg::load_funct3_t load_funct3_i,
    input  logic [1:0]             addr_offset_i,
    input  rv_wb_pkg::word_t        pc_i,
    input  rv_wb_pkg::word_t        csr_data_i,
    input  rv_wb_pkg::word_t        mdu_result_i,
    // Operand read ports from decode
    input  rv_wb_pkg::reg_addr_t    rs1_addr_i,
    input  rv_wb_pkg::reg_addr_t    rs2_addr_i,
    output rv_wb_pkg::word_t        rs1_data_o,
    output rv_wb_pkg::word_t        rs2_data_o,
    // Commit observation
    output logic                   wb_valid_o,
    output rv_wb_pkg::reg_addr_t    wb_rd_o,
    output rv_wb_pkg::word_t        wb_data_o
);

    import rv_wb_pkg::*;

    // ========================================
    // MEM/WB register outputs
    // ========================================
    logic         mw_valid;
    logic         mw_reg_write;
    reg_addr_t    mw_rd_addr;
    wb_sel_e      mw_wb_sel;
    word_t        mw_alu_result;
    word_t        mw_load_data;
    word_t        mw_pc;
    word_t        mw_csr_data;
    word_t        mw_mdu_result;
    load_funct3_t mw_load_funct3;
    logic [1:0]   mw_addr_offset;

    // Writeback commit
    logic      wb_we;
    reg_addr_t wb_rd;
    word_t     wb_data;

    // Stored operands before bypass
    word_t rf_rs1_data;
    word_t rf_rs2_data;

    mem_wb_reg u_mem_wb_reg (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .mem_valid_i   (mem_valid_i),
        .reg_write_i   (reg_write_i),
        .rd_addr_i     (rd_addr_i),
        .wb_sel_i      (wb_sel_i),
        .alu_result_i  (alu_result_i),
        .load_data_i   (load_data_i),
        .pc_i          (pc_i),
        .csr_data_i    (csr_data_i),
        .mdu_result_i  (mdu_result_i),
        .load_funct3_i (load_funct3_i),
        .addr_offset_i (addr_offset_i),
        .valid_o       (mw_valid),
        .reg_write_o   (mw_reg_write),
        .rd_addr_o     (mw_rd_addr),
        .wb_sel_o      (mw_wb_sel),
        .alu_result_o  (mw_alu_result),
        .load_data_o   (mw_load_data),
        .pc_o          (mw_pc),
        .csr_data_o    (mw_csr_data),
        .mdu_result_o  (mw_mdu_result),
        .load_funct3_o (mw_load_funct3),
        .addr_offset_o (mw_addr_offset)
    );

    writeback_stage u_writeback_stage (
        .valid_i       (mw_valid),
        .reg_write_i   (mw_reg_write),
        .rd_addr_i     (mw_rd_addr),
        .wb_sel_i      (mw_wb_sel),
        .alu_result_i  (mw_alu_result),
        .load_data_i   (mw_load_data),
        .load_funct3_i (mw_load_funct3),
        .addr_offset_i (mw_addr_offset),
        .pc_i          (mw_pc),
        .csr_data_i    (mw_csr_data),
        .mdu_result_i  (mw_mdu_result),
        .we_o          (wb_we),
        .rd_o          (wb_rd),
        .data_o        (wb_data)
    );

    // Written at the edge closing the commit cycle
    reg_file #(
        .NUM_REGS (NUM_REGS)
    ) u_reg_file (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .we_i     (wb_we),
        .waddr_i  (wb_rd),
        .wdata_i  (wb_data),
        .raddr1_i (rs1_addr_i),
        .raddr2_i (rs2_addr_i),
        .rdata1_o (rf_rs1_data),
        .rdata2_o (rf_rs2_data)
    );

    // Same-cycle view of the commit
    operand_bypass #(
        .NUM_REGS (NUM_REGS)
    ) u_operand_bypass (
        .raddr1_i   (rs1_addr_i),
        .raddr2_i   (rs2_addr_i),
        .rf_data1_i (rf_rs1_data),
        .rf_data2_i (rf_rs2_data),
        .wb_we_i    (wb_we),
        .wb_rd_i    (wb_rd),
        .wb_data_i  (wb_data),
        .op1_o      (rs1_data_o),
        .op2_o      (rs2_data_o)
    );

    // Commit observation follows the write enable
    assign wb_valid_o = wb_we;
    assign wb_rd_o    = wb_rd;
    assign wb_data_o  = wb_data;

endmodule

/* verification/tb_wb_subsystem.sv */
/*
 * Testbench for the pipeline back end
 * Random retirements checked against a shadow register model
 */

`timescale 1ns/1ps

module tb_wb_subsystem;

    import rv_wb_pkg::*;

    localparam int NUM_REGS    = 32;
    // Retirement slots offered after reset
    localparam int NUM_TXN     = 2000;
    localparam int CYCLE_LIMIT = NUM_TXN + 50;

    // ========================================
    // DUT connections
    // ========================================
    logic         clk_i;
    logic         rst_i;
    logic         mem_valid_i;
    logic         reg_write_i;
    reg_addr_t    rd_addr_i;
    wb_sel_e      wb_sel_i;
    word_t        alu_result_i;
    word_t        load_data_i;
    load_funct3_t load_funct3_i;
    logic [1:0]   addr_offset_i;
    word_t        pc_i;
    word_t        csr_data_i;
    word_t        mdu_result_i;
    reg_addr_t    rs1_addr_i;
    reg_addr_t    rs2_addr_i;
    word_t        rs1_data_o;
    word_t        rs2_data_o;
    logic         wb_valid_o;
    reg_addr_t    wb_rd_o;
    word_t        wb_data_o;

    // ========================================
    // Model state
    // ========================================
    // Committed register contents
    word_t     shadow [NUM_REGS];
    // Instruction in MEM/WB this cycle
    logic      pend_we;
    reg_addr_t pend_rd;
    word_t     pend_data;
    // Instruction strobed in this cycle
    logic      next_we;
    reg_addr_t next_rd;
    word_t     next_data;
    // Coverage of result sources and load shapes
    bit           sel_seen [5];
    bit           ld_seen [5][4];
    load_funct3_t ld_codes [5];

    integer seed;
    int     check_count = 0;
    int     error_count = 0;
    int     cycle_count = 0;
    int     txn;

    wb_subsystem #(
        .NUM_REGS (NUM_REGS)
    ) UUT (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .mem_valid_i   (mem_valid_i),
        .reg_write_i   (reg_write_i),
        .rd_addr_i     (rd_addr_i),
        .wb_sel_i      (wb_sel_i),
        .alu_result_i  (alu_result_i),
        .load_data_i   (load_data_i),
        .load_funct3_i (load_funct3_i),
        .addr_offset_i (addr_offset_i),
        .pc_i          (pc_i),
        .csr_data_i    (csr_data_i),
        .mdu_result_i  (mdu_result_i),
        .rs1_addr_i    (rs1_addr_i),
        .rs2_addr_i    (rs2_addr_i),
        .rs1_data_o    (rs1_data_o),
        .rs2_data_o    (rs2_data_o),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

    // 100 ns period
    always #50 clk_i = ~clk_i;

    // Run limit
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: no verdict after %0d cycles", cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    // ========================================
    // Checking helpers
    // ========================================

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        check_count++;
        if (got !== exp) begin
            $display("ERROR at %0t: %s, got %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    // Written value per the writeback rules
    function automatic word_t expected_result(input wb_sel_e sel, input word_t alu,
                                              input word_t ld, input load_funct3_t f3,
                                              input logic [1:0] off, input word_t pc,
                                              input word_t csr, input word_t mdu);
        logic [39:0] padded;
        logic [7:0]  lo_byte;
        logic [7:0]  hi_byte;
        word_t       loaded;
        // Bytes past the top of the word read as zero
        padded  = {8'h00, ld};
        lo_byte = padded[8*off +: 8];
        hi_byte = padded[8*off + 8 +: 8];
        case (f3)
            LD_B:    loaded = {{24{lo_byte[7]}}, lo_byte};
            LD_H:    loaded = {{16{hi_byte[7]}}, hi_byte, lo_byte};
            LD_BU:   loaded = {24'd0, lo_byte};
            LD_HU:   loaded = {16'd0, hi_byte, lo_byte};
            default: loaded = ld;
        endcase
        case (sel)
            WB_SEL_ALU:   return alu;
            WB_SEL_MEM:   return loaded;
            WB_SEL_PC_P4: return pc + 32'd4;
            WB_SEL_CSR:   return csr;
            WB_SEL_MDU:   return mdu;
            default:      return 32'd0;
        endcase
    endfunction

    // Operand value seen through bypass or storage
    function automatic word_t model_read(input reg_addr_t addr);
        if (addr == 5'd0) begin
            return 32'd0;
        end
        if (pend_we && (addr == pend_rd)) begin
            return pend_data;
        end
        return shadow[addr];
    endfunction

    // Called on the falling edge that releases reset
    task automatic check_reset;
        // All 32 indices, two per cycle
        for (int i = 0; i < 16; i++) begin
            if (i > 0) begin
                @(negedge clk_i);
            end
            rs1_addr_i = 5'(i);
            rs2_addr_i = 5'(i + 16);
            #10;
            check(32'(wb_valid_o), 32'd0, "wb_valid_o after reset");
            check(rs1_data_o, 32'd0, "rs1 read after reset");
            check(rs2_data_o, 32'd0, "rs2 read after reset");
        end
    endtask

    // ========================================
    // Stimulus
    // ========================================

    // One random retirement, strobed about three cycles in four
    task automatic drive_strobe(input bit allow);
        logic [31:0] r;
        logic [2:0]  sel_raw;
        int          ld_idx;
        r = $random(seed);
        mem_valid_i = allow && (r[1:0] != 2'b00);
        reg_write_i = (r[4:2] != 3'b000);
        rd_addr_i   = r[9:5];
        // Loads favoured so every width and offset turns up
        if (r[10]) begin
            sel_raw = 3'd1;
        end else begin
            sel_raw = r[13:11];
        end
        wb_sel_i      = wb_sel_e'(sel_raw);
        ld_idx        = int'(r[16:14]) % 5;
        load_funct3_i = ld_codes[ld_idx];
        addr_offset_i = r[18:17];
        alu_result_i  = $random(seed);
        load_data_i   = $random(seed);
        pc_i          = $random(seed);
        csr_data_i    = $random(seed);
        mdu_result_i  = $random(seed);
        next_we   = mem_valid_i && reg_write_i;
        next_rd   = rd_addr_i;
        next_data = expected_result(wb_sel_i, alu_result_i, load_data_i, load_funct3_i,
                                    addr_offset_i, pc_i, csr_data_i, mdu_result_i);
        if (next_we) begin
            if (sel_raw < 3'd5) begin
                sel_seen[int'(sel_raw)] = 1'b1;
            end
            if (sel_raw == 3'd1) begin
                ld_seen[ld_idx][int'(addr_offset_i)] = 1'b1;
            end
        end
    endtask

    task automatic report_coverage;
        for (int s = 0; s < 5; s++) begin
            if (!sel_seen[s]) begin
                $display("Result source %0d was never committed", s);
                error_count++;
            end
        end
        for (int w = 0; w < 5; w++) begin
            for (int o = 0; o < 4; o++) begin
                if (!ld_seen[w][o]) begin
                    $display("Load width %0d at offset %0d was never committed", w, o);
                    error_count++;
                end
            end
        end
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        seed          = 32199;
        clk_i         = 1'b0;
        rst_i         = 1'b1;
        mem_valid_i   = 1'b0;
        reg_write_i   = 1'b0;
        rd_addr_i     = '0;
        wb_sel_i      = WB_SEL_ALU;
        alu_result_i  = '0;
        load_data_i   = '0;
        load_funct3_i = LD_W;
        addr_offset_i = '0;
        pc_i          = '0;
        csr_data_i    = '0;
        mdu_result_i  = '0;
        rs1_addr_i    = '0;
        rs2_addr_i    = '0;
        ld_codes[0] = LD_B;
        ld_codes[1] = LD_H;
        ld_codes[2] = LD_W;
        ld_codes[3] = LD_BU;
        ld_codes[4] = LD_HU;
        for (int i = 0; i < NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        pend_we   = 1'b0;
        pend_rd   = '0;
        pend_data = '0;
        next_we   = 1'b0;
        next_rd   = '0;
        next_data = '0;

        // Reset for 4 cycles, released on a falling edge
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        check_reset();

        // Two trailing idle slots drain the last commit
        for (txn = 0; txn < NUM_TXN + 2; txn++) begin
            @(negedge clk_i);
            // Previous commit was written at the edge just passed
            if (pend_we && (pend_rd != 5'd0)) begin
                shadow[pend_rd] = pend_data;
            end
            pend_we   = next_we;
            pend_rd   = next_rd;
            pend_data = next_data;
            drive_strobe(txn < NUM_TXN);
            // rs1 follows the committing rd to exercise the bypass
            if (pend_we) begin
                rs1_addr_i = pend_rd;
            end else begin
                rs1_addr_i = 5'($random(seed));
            end
            rs2_addr_i = 5'($random(seed));
            #10;
            check(32'(wb_valid_o), 32'(pend_we), "commit valid");
            if (pend_we) begin
                check(32'(wb_rd_o), 32'(pend_rd), "commit rd");
                check(wb_data_o, pend_data, "commit data");
            end
            check(rs1_data_o, model_read(rs1_addr_i), "rs1 operand");
            check(rs2_data_o, model_read(rs2_addr_i), "rs2 operand");
        end

        // Second reset over populated registers, with a writing strobe held in
        @(negedge clk_i);
        rst_i       = 1'b1;
        mem_valid_i = 1'b1;
        reg_write_i = 1'b1;
        rd_addr_i   = 5'd1;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_i       = 1'b0;
        mem_valid_i = 1'b0;
        check_reset();

        report_coverage();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
source/rv_wb_pkg.sv
source/mem_wb_reg.sv
source/writeback_stage.sv
source/reg_file.sv
source/operand_bypass.sv
source/wb_subsystem.sv
verification/tb_wb_subsystem.sv

/* Makefile */
# Verilator build for the writeback subsystem testbench

TOOL       = verilator
TOP        = tb_wb_subsystem
FILELIST   = build.f
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The log is searched for the fail message to set the exit status
sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "No verdict in log"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
